//--- src/cp0_defines.svh
`ifndef CP0_DEFINES_SVH
`define CP0_DEFINES_SVH

// Register addresses as {number, select}
`define CP0_INDEX     {5'd0, 3'd0}
`define CP0_RANDOM    {5'd1, 3'd0}
`define CP0_ENTRYLO0  {5'd2, 3'd0}
`define CP0_ENTRYLO1  {5'd3, 3'd0}
`define CP0_CONTEXT   {5'd4, 3'd0}
`define CP0_WIRED     {5'd6, 3'd0}
`define CP0_BADVADDR  {5'd8, 3'd0}
`define CP0_COUNT     {5'd9, 3'd0}
`define CP0_ENTRYHI   {5'd10, 3'd0}
`define CP0_COMPARE   {5'd11, 3'd0}
`define CP0_STATUS    {5'd12, 3'd0}
`define CP0_CAUSE     {5'd13, 3'd0}
`define CP0_EPC       {5'd14, 3'd0}
`define CP0_PRID      {5'd15, 3'd0}
`define CP0_EBASE     {5'd15, 3'd1}
`define CP0_CONFIG    {5'd16, 3'd0}
`define CP0_CONFIG1   {5'd16, 3'd1}

`define CP0_STATUS_RST     32'h10400004 // CU0, BEV and ERL
`define CP0_EBASE_RST      32'h80000000
`define CP0_TLB_ENTRIES    16

`define CP0_STATUS_WMASK   32'h1040FF17
`define CP0_CAUSE_WMASK    32'h00800300
`define CP0_EBASE_WMASK    32'h3FFFF000
`define CP0_ENTRYHI_WMASK  32'hFFFFE0FF
`define CP0_ENTRYLO_WMASK  32'h3FFFFFFF
`define CP0_INDEX_WMASK    32'h0000000F
`define CP0_CONTEXT_WMASK  32'hFF800000
`define CP0_CONFIG_WMASK   32'h00000007

`define CP0_PRID_VAL       32'h00018000 // 4Kc style id
`define CP0_CONFIG_FIXED   32'h80000080 // Config1 present, TLB MMU
`define CP0_CONFIG1_VAL    {1'b0, 6'(`CP0_TLB_ENTRIES - 1), 25'h0}

`define COP0_OPCODE        6'b010000
`define COP0_RS_MF         5'b00000
`define COP0_RS_MT         5'b00100
`define COP0_FUNCT_ERET    6'b011000

`endif

//--- src/cp0_pkg.sv
package cp0_pkg;

    // MFC0 and MTC0 layout
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [7:0] zero;
        logic [2:0] sel;
    } cop0_move_t;

    // CO=1 layout used by ERET
    typedef struct packed {
        logic [5:0]  opcode;
        logic        co;
        logic [18:0] zero;
        logic [5:0]  funct;
    } cop0_cop_t;

    typedef union packed {
        cop0_move_t move;
        cop0_cop_t  cop;
    } cop0_instr_t;

    typedef enum logic [1:0] {
        CP0_OP_MFC0,
        CP0_OP_MTC0,
        CP0_OP_ERET,
        CP0_OP_ILL
    } cp0_op_e;

    typedef struct packed {
        logic [4:0] num;
        logic [2:0] sel;
    } cp0_addr_t;

endpackage

//--- src/cop0_decode.sv
`include "cp0_defines.svh"

module cop0_decode (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req_i,
    input  cp0_pkg::cop0_instr_t instr_i,
    input  logic [31:0]          wdata_i,
    input  logic                 done_i,
    output logic                 valid_o,
    output cp0_pkg::cp0_op_e     op_o,
    output cp0_pkg::cp0_addr_t   addr_o,
    output logic [31:0]          wdata_o
);
    import cp0_pkg::*;

    logic        busy_q;
    logic        valid_q;
    cop0_instr_t instr_q;
    logic [31:0] wdata_q;
    logic        idle;
    logic        accept;
    logic        is_cop0;
    logic        move_ok;

    assign idle   = ~busy_q | done_i; // Re-arm as the handshake closes
    assign accept = idle & req_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q  <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= accept;
            if (accept) begin
                busy_q <= 1'b1;
            end else if (done_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            instr_q <= instr_i;
            wdata_q <= wdata_i;
        end
    end

    assign is_cop0 = (instr_q.move.opcode == `COP0_OPCODE);
    assign move_ok = (instr_q.move.zero == 8'd0);

    always_comb begin
        op_o = CP0_OP_ILL;
        if (is_cop0) begin
            if (instr_q.cop.co) begin
                if (instr_q.cop.zero == 19'd0 && instr_q.cop.funct == `COP0_FUNCT_ERET) begin
                    op_o = CP0_OP_ERET;
                end
            end else if (move_ok && instr_q.move.rs == `COP0_RS_MF) begin
                op_o = CP0_OP_MFC0;
            end else if (move_ok && instr_q.move.rs == `COP0_RS_MT) begin
                op_o = CP0_OP_MTC0;
            end
        end
    end

    assign addr_o  = '{num: instr_q.move.rd, sel: instr_q.move.sel};
    assign wdata_o = wdata_q;
    assign valid_o = valid_q;

    // One issue per handshake
    valid_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        valid_o |=> !valid_o
    );

endmodule

//--- src/cp0_regfile.sv
`include "cp0_defines.svh"

module cp0_regfile (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               valid_i,
    input  cp0_pkg::cp0_op_e   op_i,
    input  cp0_pkg::cp0_addr_t addr_i,
    input  logic [31:0]        wdata_i,
    input  logic               exc_i,
    input  logic [4:0]         exc_code_i,
    input  logic [31:0]        exc_epc_i,
    input  logic               exc_bd_i,
    input  logic [31:0]        exc_badv_i,
    input  logic [5:0]         hw_int_i,
    output logic               valid_o,
    output logic [31:0]        rdata_o,
    output logic               ill_o,
    output logic               timer_int_o,
    output logic               in_exl_o,
    output logic               user_mode_o,
    output logic               allow_int_o,
    output logic [7:0]         int_mask_o,
    output logic [19:0]        ebase_o,
    output logic [31:0]        epc_o,
    output logic               bev_o,
    output logic               kseg0_uncached_o
);
    import cp0_pkg::*;

    localparam int RND_W = $clog2(`CP0_TLB_ENTRIES);

    logic [31:0]      index_q;
    logic [31:0]      entrylo0_q;
    logic [31:0]      entrylo1_q;
    logic [31:0]      context_q;
    logic [RND_W-1:0] wired_q;
    logic [RND_W-1:0] random_q;
    logic [31:0]      badvaddr_q;
    logic [31:0]      count_q;
    logic [31:0]      entryhi_q;
    logic [31:0]      compare_q;
    logic [31:0]      status_q;
    logic [31:0]      cause_q;
    logic [31:0]      epc_q;
    logic [31:0]      ebase_q;
    logic [31:0]      config_q;
    logic             timer_q;

    logic             wr_en;
    logic             eret;
    logic [31:0]      rd_val;
    logic             valid_q;
    logic             ill_q;
    logic [31:0]      rdata_q;

    function automatic logic [31:0] mwrite(input logic [31:0] old_val,
                                           input logic [31:0] data,
                                           input logic [31:0] mask);
        return (old_val & ~mask) | (data & mask);
    endfunction

    assign wr_en = valid_i && (op_i == CP0_OP_MTC0);
    assign eret  = valid_i && (op_i == CP0_OP_ERET);

    always_comb begin
        case (addr_i)
            `CP0_INDEX:    rd_val = index_q;
            `CP0_RANDOM:   rd_val = {{(32-RND_W){1'b0}}, random_q};
            `CP0_ENTRYLO0: rd_val = entrylo0_q;
            `CP0_ENTRYLO1: rd_val = entrylo1_q;
            `CP0_CONTEXT:  rd_val = {context_q[31:4], 4'b0};
            `CP0_WIRED:    rd_val = {{(32-RND_W){1'b0}}, wired_q};
            `CP0_BADVADDR: rd_val = badvaddr_q;
            `CP0_COUNT:    rd_val = count_q;
            `CP0_ENTRYHI:  rd_val = entryhi_q;
            `CP0_COMPARE:  rd_val = compare_q;
            `CP0_STATUS:   rd_val = status_q;
            `CP0_CAUSE:    rd_val = {cause_q[31], 7'b0, cause_q[23], 7'b0, hw_int_i,
                                     cause_q[9:8], 1'b0, cause_q[6:2], 2'b0};
            `CP0_EPC:      rd_val = epc_q;
            `CP0_PRID:     rd_val = `CP0_PRID_VAL;
            `CP0_EBASE:    rd_val = {2'b10, ebase_q[29:12], 12'b0};
            `CP0_CONFIG:   rd_val = `CP0_CONFIG_FIXED | {29'b0, config_q[2:0]};
            `CP0_CONFIG1:  rd_val = `CP0_CONFIG1_VAL;
            default:       rd_val = 32'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            index_q    <= 32'b0;
            entrylo0_q <= 32'b0;
            entrylo1_q <= 32'b0;
            context_q  <= 32'b0;
            wired_q    <= '0;
            random_q   <= RND_W'(`CP0_TLB_ENTRIES - 1);
            count_q    <= 32'b0;
            entryhi_q  <= 32'b0;
            compare_q  <= 32'b0;
            status_q   <= `CP0_STATUS_RST;
            cause_q    <= 32'b0;
            ebase_q    <= `CP0_EBASE_RST;
            config_q   <= 32'b0;
            timer_q    <= 1'b0;
        end else begin
            count_q <= count_q + 32'd1;
            if (compare_q != 32'b0 && compare_q == count_q) begin
                timer_q <= 1'b1;
            end
            if (wr_en) begin
                case (addr_i)
                    `CP0_INDEX:    index_q <= mwrite(index_q, wdata_i, `CP0_INDEX_WMASK);
                    `CP0_ENTRYLO0: entrylo0_q <= mwrite(entrylo0_q, wdata_i, `CP0_ENTRYLO_WMASK);
                    `CP0_ENTRYLO1: entrylo1_q <= mwrite(entrylo1_q, wdata_i, `CP0_ENTRYLO_WMASK);
                    `CP0_CONTEXT:  context_q <= mwrite(context_q, wdata_i, `CP0_CONTEXT_WMASK);
                    `CP0_WIRED: begin
                        wired_q  <= wdata_i[RND_W-1:0];
                        random_q <= RND_W'(`CP0_TLB_ENTRIES - 1);
                    end
                    `CP0_COUNT:    count_q <= wdata_i;
                    `CP0_ENTRYHI:  entryhi_q <= mwrite(entryhi_q, wdata_i, `CP0_ENTRYHI_WMASK);
                    `CP0_COMPARE: begin
                        compare_q <= wdata_i;
                        timer_q   <= 1'b0; // Acknowledges the timer
                    end
                    `CP0_STATUS:   status_q <= mwrite(status_q, wdata_i, `CP0_STATUS_WMASK);
                    `CP0_CAUSE:    cause_q <= mwrite(cause_q, wdata_i, `CP0_CAUSE_WMASK);
                    `CP0_EPC:      epc_q <= wdata_i;
                    `CP0_EBASE:    ebase_q <= mwrite(ebase_q, wdata_i, `CP0_EBASE_WMASK);
                    `CP0_CONFIG:   config_q <= mwrite(config_q, wdata_i, `CP0_CONFIG_WMASK);
                    default: ;
                endcase
            end
            if (eret) begin
                if (status_q[2]) begin
                    status_q[2] <= 1'b0; // ERL first
                end else begin
                    status_q[1] <= 1'b0;
                end
            end
            // Exception entry overrides the instruction path
            if (exc_i) begin
                status_q[1]         <= 1'b1;
                cause_q[31]         <= exc_bd_i;
                cause_q[6:2]        <= exc_code_i;
                epc_q               <= exc_epc_i;
                badvaddr_q          <= exc_badv_i;
                context_q[22:4]     <= exc_badv_i[31:13];
                entryhi_q[31:13]    <= exc_badv_i[31:13];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            ill_q   <= 1'b0;
        end else begin
            valid_q <= valid_i;
            if (valid_i) begin
                ill_q <= (op_i == CP0_OP_ILL);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            rdata_q <= (op_i == CP0_OP_MFC0) ? rd_val : 32'b0;
        end
    end

    assign valid_o          = valid_q;
    assign rdata_o          = rdata_q;
    assign ill_o            = ill_q;
    assign timer_int_o      = timer_q;
    assign in_exl_o         = status_q[1];
    assign user_mode_o      = (status_q[4:1] == 4'b1000); // UM set, EXL and ERL clear
    assign allow_int_o      = (status_q[2:0] == 3'b001);
    assign int_mask_o       = status_q[15:8];
    assign ebase_o          = {2'b10, ebase_q[29:12]};
    assign epc_o            = epc_q;
    assign bev_o            = status_q[22];
    assign kseg0_uncached_o = (config_q[2:0] == 3'd2);

    exc_sets_exl: assert property (
        @(posedge clk) disable iff (!rst_n)
        exc_i |=> status_q[1]
    );

endmodule

//--- src/cop0_result.sv
module cop0_result (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        valid_i,
    input  logic [31:0] rdata_i,
    input  logic        ill_i,
    input  logic        req_i,
    output logic        ack_o,
    output logic [31:0] rdata_o,
    output logic        ill_o,
    output logic        done_o
);

    logic        ack_q;
    logic        ill_q;
    logic        done_q;
    logic [31:0] rdata_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q  <= 1'b0;
            ill_q  <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (valid_i) begin
                ack_q <= 1'b1;
                ill_q <= ill_i;
            end else if (ack_q && !req_i) begin
                ack_q  <= 1'b0; // Master has dropped req
                done_q <= 1'b1;
            end
        end
    end

    // Answer stays stable while ack is high
    always_ff @(posedge clk) begin
        if (valid_i) begin
            rdata_q <= rdata_i;
        end
    end

    assign ack_o   = ack_q;
    assign rdata_o = rdata_q;
    assign ill_o   = ill_q;
    assign done_o  = done_q;

    // Req as sampled on the edge that raised ack
    ack_needs_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(ack_o) |-> $past(req_i)
    );

endmodule

//--- src/cop0_unit.sv
module cop0_unit (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req_i,
    input  logic [31:0] instr_i,
    input  logic [31:0] wdata_i,
    output logic        ack_o,
    output logic [31:0] rdata_o,
    output logic        ill_o,
    input  logic        exc_i,
    input  logic [4:0]  exc_code_i,
    input  logic [31:0] exc_epc_i,
    input  logic        exc_bd_i,
    input  logic [31:0] exc_badv_i,
    input  logic [5:0]  hw_int_i,
    output logic        timer_int_o,
    output logic        in_exl_o,
    output logic        user_mode_o,
    output logic        allow_int_o,
    output logic [7:0]  int_mask_o,
    output logic [19:0] ebase_o,
    output logic [31:0] epc_o,
    output logic        bev_o,
    output logic        kseg0_uncached_o
);
    import cp0_pkg::*;

    logic        dec_valid;
    cp0_op_e     dec_op;
    cp0_addr_t   dec_addr;
    logic [31:0] dec_wdata;
    logic        ex_valid;
    logic [31:0] ex_rdata;
    logic        ex_ill;
    logic        done;

    cop0_decode cop0_decode_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_i   (req_i),
        .instr_i (instr_i),
        .wdata_i (wdata_i),
        .done_i  (done),
        .valid_o (dec_valid),
        .op_o    (dec_op),
        .addr_o  (dec_addr),
        .wdata_o (dec_wdata)
    );

    cp0_regfile cp0_regfile_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .valid_i          (dec_valid),
        .op_i             (dec_op),
        .addr_i           (dec_addr),
        .wdata_i          (dec_wdata),
        .exc_i            (exc_i),
        .exc_code_i       (exc_code_i),
        .exc_epc_i        (exc_epc_i),
        .exc_bd_i         (exc_bd_i),
        .exc_badv_i       (exc_badv_i),
        .hw_int_i         (hw_int_i),
        .valid_o          (ex_valid),
        .rdata_o          (ex_rdata),
        .ill_o            (ex_ill),
        .timer_int_o      (timer_int_o),
        .in_exl_o         (in_exl_o),
        .user_mode_o      (user_mode_o),
        .allow_int_o      (allow_int_o),
        .int_mask_o       (int_mask_o),
        .ebase_o          (ebase_o),
        .epc_o            (epc_o),
        .bev_o            (bev_o),
        .kseg0_uncached_o (kseg0_uncached_o)
    );

    cop0_result cop0_result_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .valid_i (ex_valid),
        .rdata_i (ex_rdata),
        .ill_i   (ex_ill),
        .req_i   (req_i),
        .ack_o   (ack_o),
        .rdata_o (rdata_o),
        .ill_o   (ill_o),
        .done_o  (done)
    );

endmodule

//--- sim/cop0_unit_tb.sv
`include "cp0_defines.svh"

module cop0_unit_tb;
    import cp0_pkg::*;

    localparam int          CLK_PERIOD   = 8;
    localparam int          DRIVE_DLY    = 1;
    localparam int          RESET_CYCLES = 5;
    localparam logic [15:0] SEED         = 16'd18166;
    localparam int          TIMER_BOUND  = 80;
    localparam int          TIMEOUT_PAD  = 200;
    localparam logic [5:0]  HW_INT       = 6'b100101;

    // Entry kinds
    localparam logic [2:0] K_MF = 3'd0, K_MT = 3'd1, K_ERET = 3'd2;
    localparam logic [2:0] K_BADOP = 3'd3, K_BADFN = 3'd4, K_TIMER = 3'd5;
    // Output checks after an entry
    localparam logic [2:0] C_NONE = 3'd0, C_STATUS = 3'd1, C_KSEG0 = 3'd2;
    localparam logic [2:0] C_TIMER = 3'd3, C_EXL = 3'd4, C_EBASE = 3'd5;

    typedef struct packed {
        logic [2:0]  kind;
        cp0_addr_t   addr;
        logic [31:0] wdata;     // Also the EPC of an exception event
        logic        exc;
        logic [4:0]  exc_code;
        logic        exc_bd;
        logic [31:0] exc_badv;
        logic [31:0] exp_val;
        logic        exp_ill;
        logic [2:0]  chk;
        logic        exp_flag;
    } stim_t;

    logic        clk;
    logic        rst_n;
    logic        req_i;
    logic [31:0] instr_i;
    logic [31:0] wdata_i;
    logic        ack_o;
    logic [31:0] rdata_o;
    logic        ill_o;
    logic        exc_i;
    logic [4:0]  exc_code_i;
    logic [31:0] exc_epc_i;
    logic        exc_bd_i;
    logic [31:0] exc_badv_i;
    logic [5:0]  hw_int_i;
    logic        timer_int_o;
    logic        in_exl_o;
    logic        user_mode_o;
    logic        allow_int_o;
    logic [7:0]  int_mask_o;
    logic [19:0] ebase_o;
    logic [31:0] epc_o;
    logic        bev_o;
    logic        kseg0_uncached_o;

    stim_t       stim_q[$];
    logic [15:0] lfsr_q = SEED;
    int          cycles = 0;

    cop0_unit cop0_unit_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int b = 0; b < n; b++) begin
            v[b] = lfsr_q[0];
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_with_failure("Word mismatch");
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp);
            stop_with_failure("Flag mismatch");
        end
    endtask

    task automatic check_op(input string what, input cp0_op_e got, input cp0_op_e exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
            stop_with_failure("Decoded operation mismatch");
        end
    endtask

    function automatic cp0_op_e kind_op(input logic [2:0] kind);
        case (kind)
            K_MF:    return CP0_OP_MFC0;
            K_MT:    return CP0_OP_MTC0;
            K_ERET:  return CP0_OP_ERET;
            default: return CP0_OP_ILL;
        endcase
    endfunction

    function automatic cop0_instr_t make_instr(input logic [2:0] kind, input cp0_addr_t addr);
        cop0_instr_t w;
        w = '0;
        case (kind)
            K_MF, K_MT, K_BADOP: begin
                w.move.opcode = (kind == K_BADOP) ? 6'b100011 : `COP0_OPCODE;
                w.move.rs     = (kind == K_MF) ? `COP0_RS_MF : `COP0_RS_MT;
                w.move.rt     = 5'd8;
                w.move.rd     = addr.num;
                w.move.sel    = addr.sel;
            end
            default: begin
                w.cop.opcode = `COP0_OPCODE;
                w.cop.co     = 1'b1;
                w.cop.funct  = (kind == K_ERET) ? `COP0_FUNCT_ERET : 6'b111111;
            end
        endcase
        return w;
    endfunction

    task automatic push_instr(input logic [2:0] kind, input cp0_addr_t addr,
                              input logic [31:0] wdata, input logic [31:0] exp_val,
                              input logic exp_ill, input logic [2:0] chk, input logic exp_flag);
        stim_t e;
        e = '0;
        e.kind     = kind;
        e.addr     = addr;
        e.wdata    = wdata;
        e.exp_val  = exp_val;
        e.exp_ill  = exp_ill;
        e.chk      = chk;
        e.exp_flag = exp_flag;
        stim_q.push_back(e);
    endtask

    task automatic push_exc(input logic [4:0] code, input logic [31:0] epc,
                            input logic bd, input logic [31:0] badv);
        stim_t e;
        e = '0;
        e.exc      = 1'b1;
        e.exc_code = code;
        e.wdata    = epc;
        e.exc_bd   = bd;
        e.exc_badv = badv;
        e.exp_val  = epc;
        e.chk      = C_EXL;
        e.exp_flag = 1'b1;
        stim_q.push_back(e);
    endtask

    task automatic build_stimulus();
        logic [31:0] st, ca, eh, el0, el1, idx, ctx, eb, cfg;
        logic [31:0] code, epc, bd, badv, cause_w;
        take_bits(32, st);
        take_bits(32, ca);
        take_bits(32, eh);
        take_bits(32, el0);
        take_bits(32, el1);
        take_bits(32, idx);
        take_bits(32, ctx);
        take_bits(32, eb);
        take_bits(32, cfg);
        take_bits(5, code);
        take_bits(32, epc);
        take_bits(1, bd);
        take_bits(32, badv);
        cause_w = ca & `CP0_CAUSE_WMASK;
        push_instr(K_MF, `CP0_STATUS, 0, 32'h10400004, 0, C_STATUS, 0);
        push_instr(K_MF, `CP0_EBASE, 0, 32'h80000000, 0, C_EBASE, 0);
        push_instr(K_MF, `CP0_PRID, 0, `CP0_PRID_VAL, 0, C_NONE, 0);
        push_instr(K_MF, `CP0_CONFIG1, 0, `CP0_CONFIG1_VAL, 0, C_NONE, 0);
        push_instr(K_MF, `CP0_RANDOM, 0, 32'd15, 0, C_NONE, 0);
        push_instr(K_MT, `CP0_STATUS, st, st & `CP0_STATUS_WMASK, 0, C_STATUS, 0);
        push_instr(K_MF, `CP0_STATUS, 0, st & `CP0_STATUS_WMASK, 0, C_NONE, 0);
        push_instr(K_MT, `CP0_CAUSE, ca, 0, 0, C_NONE, 0);
        push_instr(K_MF, `CP0_CAUSE, 0, cause_w | {16'b0, HW_INT, 10'b0}, 0, C_NONE, 0);
        push_instr(K_MT, `CP0_ENTRYHI, eh, 0, 0, C_NONE, 0);
        push_instr(K_MF, `CP0_ENTRYHI, 0, eh & `CP0_ENTRYHI_WMASK, 0, C_NONE, 0);
        push_instr(K_MT, `CP0_ENTRYLO0, el0, 0, 0, C_NONE, 0);
        push_instr(K_MF, `CP0_ENTRYLO0, 0, el0 & `CP0_ENTRYLO_WMASK, 0, C_NONE, 0);
        push_instr(K_MT, `CP0_ENTRYLO1, el1, 0, 0, C_NONE, 0);
        push_instr(K_MF, `CP0_ENTRYLO1, 0, el1 & `CP0_ENTRYLO_WMASK, 0, C_NONE, 0);
        push_instr(K_MT, `CP0_INDEX, idx, 0, 0, C_NONE, 0);
        push_instr(K_MF, `CP0_INDEX, 0, idx & `CP0_INDEX_WMASK, 0, C_NONE, 0);
        push_instr(K_MT, `CP0_CONTEXT, ctx, 0, 0, C_NONE, 0);
        push_instr(K_MF, `CP0_CONTEXT, 0, ctx & `CP0_CONTEXT_WMASK, 0, C_NONE, 0);
        push_instr(K_MT, `CP0_EBASE, eb, 0, 0, C_NONE, 0);
        push_instr(K_MF, `CP0_EBASE, 0, (eb & `CP0_EBASE_WMASK) | 32'h80000000,
                   0, C_EBASE, 0);
        push_instr(K_MT, `CP0_CONFIG, cfg, 0, 0, C_KSEG0, cfg[2:0] == 3'd2);
        push_instr(K_MF, `CP0_CONFIG, 0, `CP0_CONFIG_FIXED | (cfg & 32'h7), 0, C_NONE, 0);
        push_instr(K_MT, `CP0_CONFIG, 32'd2, 0, 0, C_KSEG0, 1);
        push_instr(K_MF, `CP0_CONFIG, 0, `CP0_CONFIG_FIXED | 32'd2, 0, C_NONE, 0);
        // Count restarts from zero and fires at Compare
        push_instr(K_MT, `CP0_COUNT, 32'd0, 0, 0, C_NONE, 0);
        push_instr(K_MT, `CP0_COMPARE, 32'd40, 0, 0, C_TIMER, 0);
        push_instr(K_MF, `CP0_COMPARE, 0, 32'd40, 0, C_TIMER, 0);
        push_instr(K_TIMER, '0, 0, 0, 0, C_TIMER, 1);
        push_instr(K_MT, `CP0_COMPARE, 32'd0, 0, 0, C_TIMER, 0);
        // UM and IE set, EXL and ERL clear
        push_instr(K_MT, `CP0_STATUS, 32'h0000FF11, 32'h0000FF11, 0, C_STATUS, 0);
        push_exc(code[4:0], epc, bd[0], badv);
        push_instr(K_MF, `CP0_CAUSE, 0,
                   cause_w | {bd[0], 15'b0, HW_INT, 10'b0} | {25'b0, code[4:0], 2'b0},
                   0, C_NONE, 0);
        push_instr(K_MF, `CP0_EPC, 0, epc, 0, C_NONE, 0);
        push_instr(K_MF, `CP0_BADVADDR, 0, badv, 0, C_NONE, 0);
        push_instr(K_MF, `CP0_ENTRYHI, 0, (badv & 32'hFFFFE000) | (eh & 32'h000000FF),
                   0, C_NONE, 0);
        push_instr(K_ERET, '0, 0, 0, 0, C_EXL, 0);
        push_instr(K_MF, `CP0_STATUS, 0, 32'h0000FF11, 0, C_STATUS, 0);
        push_instr(K_BADOP, `CP0_STATUS, 32'hFFFFFFFF, 0, 1, C_NONE, 0);
        push_instr(K_BADFN, '0, 0, 0, 1, C_NONE, 0);
        push_instr(K_MF, `CP0_STATUS, 0, 32'h0000FF11, 0, C_STATUS, 0);
    endtask

    // Four-phase transfer entered and left 1 unit after a rising edge
    task automatic run_handshake(input cop0_instr_t instr, input logic [31:0] data,
                                 output logic [31:0] rdata, output logic ill,
                                 output cp0_op_e op);
        logic seen;
        seen    = 1'b0;
        op      = CP0_OP_ILL;
        instr_i = instr;
        wdata_i = data;
        req_i   = 1'b1;
        do begin
            @(posedge clk);
            #DRIVE_DLY;
            if (cop0_unit_inst.dec_valid) begin
                op   = cop0_unit_inst.dec_op;
                seen = 1'b1;
            end
        end while (!ack_o);
        rdata = rdata_o;
        ill   = ill_o;
        req_i = 1'b0;
        do begin
            @(posedge clk);
            #DRIVE_DLY;
        end while (ack_o);
        if (!seen) begin
            stop_with_failure("Request was answered without being decoded");
        end
    endtask

    task automatic apply_entry(input int i, input stim_t e);
        logic [31:0] rd;
        logic        ill;
        cp0_op_e     op;
        int          n;
        if (e.exc) begin
            exc_code_i = e.exc_code;
            exc_epc_i  = e.wdata;
            exc_bd_i   = e.exc_bd;
            exc_badv_i = e.exc_badv;
            exc_i      = 1'b1;
            @(posedge clk);
            #DRIVE_DLY;
            exc_i = 1'b0;
            check_word($sformatf("entry %0d epc_o", i), epc_o, e.exp_val);
        end else if (e.kind == K_TIMER) begin
            n = 0;
            while (!timer_int_o && n < TIMER_BOUND) begin
                @(posedge clk);
                #DRIVE_DLY;
                n++;
            end
            if (!timer_int_o) begin
                stop_with_failure("Timer interrupt did not rise within the wait bound");
            end
        end else begin
            run_handshake(make_instr(e.kind, e.addr), e.wdata, rd, ill, op);
            check_op($sformatf("entry %0d decoded op", i), op, kind_op(e.kind));
            check_flag($sformatf("entry %0d ill_o", i), ill, e.exp_ill);
            if (e.kind == K_MF) begin
                check_word($sformatf("entry %0d read data", i), rd, e.exp_val);
            end
        end
        case (e.chk)
            C_STATUS: begin
                check_word($sformatf("entry %0d int_mask_o", i), {24'b0, int_mask_o},
                           {24'b0, e.exp_val[15:8]});
                check_flag($sformatf("entry %0d user_mode_o", i), user_mode_o,
                           e.exp_val[4:1] == 4'b1000);
                check_flag($sformatf("entry %0d allow_int_o", i), allow_int_o,
                           e.exp_val[2:0] == 3'b001);
                check_flag($sformatf("entry %0d bev_o", i), bev_o, e.exp_val[22]);
            end
            C_KSEG0: check_flag($sformatf("entry %0d kseg0", i), kseg0_uncached_o, e.exp_flag);
            C_TIMER: check_flag($sformatf("entry %0d timer_int_o", i), timer_int_o, e.exp_flag);
            C_EXL:   check_flag($sformatf("entry %0d in_exl_o", i), in_exl_o, e.exp_flag);
            C_EBASE: check_word($sformatf("entry %0d ebase_o", i), {12'b0, ebase_o},
                                {12'b0, e.exp_val[31:12]});
            default: ;
        endcase
    endtask

    initial begin
        req_i      = 1'b0;
        instr_i    = '0;
        wdata_i    = '0;
        exc_i      = 1'b0;
        exc_code_i = '0;
        exc_epc_i  = '0;
        exc_bd_i   = 1'b0;
        exc_badv_i = '0;
        hw_int_i   = HW_INT;
        rst_n      = 1'b0;
        build_stimulus();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        check_flag("ack_o after reset", ack_o, 1'b0);
        check_flag("in_exl_o after reset", in_exl_o, 1'b0);
        check_flag("allow_int_o after reset", allow_int_o, 1'b0);
        check_flag("timer_int_o after reset", timer_int_o, 1'b0);
        check_flag("kseg0_uncached_o after reset", kseg0_uncached_o, 1'b0);
        check_flag("bev_o after reset", bev_o, 1'b1);
        for (int i = 0; i < stim_q.size(); i++) begin
            apply_entry(i, stim_q[i]);
        end
        $display("NO ERRORS");
        $finish;
    end

    // Watchdog sized from the table
    initial begin
        int limit;
        @(posedge clk);
        limit = stim_q.size() * 12 + TIMEOUT_PAD;
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped");
    end

endmodule

//--- flist.f
+incdir+src
src/cp0_pkg.sv
src/cop0_decode.sv
src/cp0_regfile.sv
src/cop0_result.sv
src/cop0_unit.sv
sim/cop0_unit_tb.sv

//--- Bender.yml
package:
  name: cop0_unit

sources:
  - include_dirs:
      - src
    files:
      - src/cp0_pkg.sv
      - src/cop0_decode.sv
      - src/cp0_regfile.sv
      - src/cop0_result.sv
      - src/cop0_unit.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/cop0_unit_tb.sv
